/* project.f */
rtl/smpte352_pkg.sv
rtl/trs_detect.sv
rtl/line_counter.sv
rtl/anc_sequencer.sv
rtl/payload_merge.sv
rtl/smpte352_insert.sv
tb/tb_smpte352_insert.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SMPTE 352 inserter simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_smpte352_insert \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi

/* tb/tb_smpte352_insert.sv */
// Testbench for the SMPTE 352 payload ID inserter
// Random shortened HD-SDI frames of each standard with vid_en gaps,
// a line and packet model, and per-sample output checks

`timescale 1ns/1ps

module tb_smpte352_insert;

  localparam smpte352_pkg::line_num_t ANC_F1 = 11'd10;
  localparam smpte352_pkg::line_num_t ANC_F2 = 11'd572;
  // Two frames of four standards plus one disabled 1080i frame
  localparam int TOTAL_LINES      = 2 * 1125 * 2 + 2 * 750 * 2 + 1125;
  localparam int MAX_LINE_SAMPLES = 41;
  localparam int WATCHDOG_NS      = TOTAL_LINES * MAX_LINE_SAMPLES * 10 * 2 + 1000;

  logic                      vid_clk;
  logic                      vid_reset;
  logic                      vid_en;
  logic                      enable_anc;
  smpte352_pkg::vid_std_t    vid_std;
  smpte352_pkg::vid_sample_t vid_data;
  logic                      vid_out_en;
  smpte352_pkg::vid_sample_t vid_out_data;
  smpte352_pkg::line_num_t   line;

  integer                    seed;
  string                     test_name;
  smpte352_pkg::vid_sample_t exp_q[$];
  smpte352_pkg::vid_sample_t exp_s;
  smpte352_pkg::vid_std_t    cur_std;
  logic                      anc_on;
  logic                      pkt_line;
  smpte352_pkg::line_num_t   model_line;
  logic                      model_vprev;
  logic                      en_prev;
  int                        sample_errors;
  int                        line_errors;
  int                        en_errors;
  int                        other_errors;

  smpte352_insert #(
    .ANC_LINE_F1 (ANC_F1),
    .ANC_LINE_F2 (ANC_F2)
  ) u_smpte352_insert (
    .vid_clk      (vid_clk),
    .vid_reset    (vid_reset),
    .vid_en       (vid_en),
    .enable_anc   (enable_anc),
    .vid_std      (vid_std),
    .vid_data     (vid_data),
    .vid_out_en   (vid_out_en),
    .vid_out_data (vid_out_data),
    .line         (line)
  );

  initial begin
    vid_clk = 1'b0;
    forever #5 vid_clk = ~vid_clk;
  end

  // --------------------------------------------------
  // Standard decode and packet words
  // --------------------------------------------------
  function automatic logic std_is_720(input smpte352_pkg::vid_std_t vs);
    return (vs[27:24] == 4'h4) || (vs[27:24] == 4'h8);
  endfunction

  function automatic logic std_is_3g(input smpte352_pkg::vid_std_t vs);
    return (vs[27:24] == 4'h8) || (vs[27:24] == 4'h9);
  endfunction

  function automatic logic std_interlaced(input smpte352_pkg::vid_std_t vs);
    return std_is_720(vs) ? !vs[22] : !vs[23];
  endfunction

  function automatic smpte352_pkg::vid_word_t parity_coded(input logic [7:0] b);
    logic p;
    p = ^b;
    return {~p, p, b};
  endfunction

  // DID through UDW3, k counted from the first ADF word
  function automatic smpte352_pkg::vid_word_t data_word(input int k,
                                                        input smpte352_pkg::vid_std_t vs);
    case (k)
      3:       return 10'h241;
      4:       return 10'h101;
      5:       return 10'h104;
      6:       return parity_coded(vs[31:24]);
      7:       return parity_coded(vs[23:16]);
      8:       return parity_coded(vs[15:8]);
      default: return parity_coded(vs[7:0]);
    endcase
  endfunction

  function automatic smpte352_pkg::vid_word_t packet_word(input int k,
                                                          input smpte352_pkg::vid_std_t vs);
    logic [8:0]              sum;
    smpte352_pkg::vid_word_t w;
    int                      j;
    sum = 9'h000;
    if (k == 0) begin
      return 10'h000;
    end else if (k <= 2) begin
      return 10'h3FF;
    end else if (k <= 9) begin
      return data_word(k, vs);
    end
    for (j = 3; j <= 9; j++) begin
      w   = data_word(j, vs);
      sum = sum + w[8:0];
    end
    return {~sum[8], sum};
  endfunction

  // F and V flags of a frame line, returned as {F, V}
  function automatic logic [1:0] frame_fv(input int l, input smpte352_pkg::vid_std_t vs);
    if (std_is_720(vs)) begin
      return {1'b0, (l <= 25) || (l >= 746)};
    end else if (!vs[23]) begin
      return {l >= 563, (l <= 20) || (l >= 561 && l <= 583) || (l >= 1124)};
    end
    return {1'b0, (l <= 41) || (l >= 1122)};
  endfunction

  function automatic smpte352_pkg::vid_word_t trs_xyz(input logic f, input logic v,
                                                      input logic h);
    return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h, 2'b00};
  endfunction

  // Random word that never looks like a TRS value
  function automatic smpte352_pkg::vid_word_t rand_word();
    logic [31:0] r;
    do begin
      r = $random(seed);
    end while (r[9:0] == 10'h000 || r[9:0] == 10'h3FF);
    return r[9:0];
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_sample(input string name, input smpte352_pkg::vid_sample_t exp,
                              input smpte352_pkg::vid_sample_t act);
    if (act !== exp) begin
      sample_errors++;
      $display("ERROR %s: sample expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_line(input string name, input smpte352_pkg::line_num_t exp,
                            input smpte352_pkg::line_num_t act);
    if (act !== exp) begin
      line_errors++;
      $display("ERROR %s: line expected %0d actual %0d at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_enable(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      en_errors++;
      $display("ERROR %s: vid_out_en expected %b actual %b at %0t", name, exp, act, $time);
    end
  endtask

  // --------------------------------------------------
  // Stimulus and model
  // --------------------------------------------------
  task automatic drive_sample(input smpte352_pkg::vid_sample_t s, input int idx);
    logic [31:0]               r;
    smpte352_pkg::vid_sample_t exp;
    r = $random(seed);
    if (r[2:0] == 3'd0) begin
      @(posedge vid_clk);
      vid_en   <= 1'b0;
      vid_data <= r[31:12];
    end
    @(posedge vid_clk);
    vid_en   <= 1'b1;
    vid_data <= s;
    exp = s;
    // Packet lands on samples 5 to 15 after the XYZ word
    if (pkt_line && idx >= 5 && idx <= 15) begin
      exp[19:10] = packet_word(idx - 5, cur_std);
      if (std_is_3g(cur_std)) begin
        exp[9:0] = packet_word(idx - 5, cur_std);
      end
    end
    exp_q.push_back(exp);
  endtask

  task automatic advance_model(input logic f, input logic v);
    if (!v && model_vprev && !f) begin
      if (std_is_720(cur_std)) begin
        model_line = 11'd26;
      end else begin
        model_line = cur_std[23] ? 11'd42 : 11'd21;
      end
    end else if (model_line >= (std_is_720(cur_std) ? 11'd750 : 11'd1125)) begin
      model_line = 11'd1;
    end else begin
      model_line = model_line + 11'd1;
    end
    model_vprev = v;
    pkt_line = anc_on &&
               (model_line == ANC_F1 || (std_interlaced(cur_std) && model_line == ANC_F2));
  endtask

  task automatic send_line(input int l);
    logic [1:0]              fv;
    logic [31:0]             r;
    smpte352_pkg::vid_word_t xyz;
    int                      nb;
    int                      na;
    int                      i;
    fv = frame_fv(l, cur_std);
    advance_model(fv[1], fv[0]);
    xyz = trs_xyz(fv[1], fv[0], 1'b1);
    drive_sample({10'h3FF, 10'h3FF}, -3);
    drive_sample(20'h00000, -2);
    drive_sample(20'h00000, -1);
    drive_sample({xyz, xyz}, 0);
    // LN and CRC words
    for (i = 1; i <= 4; i++) begin
      drive_sample({rand_word(), rand_word()}, i);
    end
    check_line(test_name, model_line, line);
    r  = $random(seed);
    nb = 12 + r[2:0];
    na = 4 + r[5:4];
    for (i = 0; i < nb; i++) begin
      drive_sample({rand_word(), rand_word()}, 5 + i);
    end
    xyz = trs_xyz(fv[1], fv[0], 1'b0);
    drive_sample({10'h3FF, 10'h3FF}, 99);
    drive_sample(20'h00000, 99);
    drive_sample(20'h00000, 99);
    drive_sample({xyz, xyz}, 99);
    for (i = 0; i < na; i++) begin
      drive_sample({rand_word(), rand_word()}, 99);
    end
  endtask

  task automatic run_frames(input string name, input logic [15:0] std_hi,
                            input logic en, input int frames);
    logic [31:0] r;
    int          fr;
    int          l;
    r         = $random(seed);
    test_name = name;
    cur_std   = {std_hi, r[15:0]};
    anc_on    = en;
    @(posedge vid_clk);
    vid_en     <= 1'b0;
    vid_std    <= cur_std;
    enable_anc <= en;
    for (fr = 0; fr < frames; fr++) begin
      for (l = 1; l <= (std_is_720(cur_std) ? 750 : 1125); l++) begin
        send_line(l);
      end
    end
  endtask

  // --------------------------------------------------
  // Output monitor
  // --------------------------------------------------
  always @(posedge vid_clk) begin
    if (vid_reset) begin
      en_prev = 1'b0;
    end else begin
      check_enable(test_name, en_prev, vid_out_en);
      if (vid_out_en === 1'b1) begin
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Output sample appeared with nothing expected at %0t", $time);
        end else begin
          exp_s = exp_q.pop_front();
          check_sample(test_name, exp_s, vid_out_data);
        end
      end
      en_prev = vid_en;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the stimulus finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    seed          = 32'h35b9_e0ac;
    vid_reset     = 1'b1;
    vid_en        = 1'b0;
    enable_anc    = 1'b0;
    vid_std       = '0;
    vid_data      = '0;
    test_name     = "reset";
    cur_std       = '0;
    anc_on        = 1'b0;
    pkt_line      = 1'b0;
    model_line    = '0;
    model_vprev   = 1'b0;
    sample_errors = 0;
    line_errors   = 0;
    en_errors     = 0;
    other_errors  = 0;
    repeat (5) @(posedge vid_clk);
    vid_reset <= 1'b0;

    run_frames("1080i_1g5", 16'h8506, 1'b1, 2);
    run_frames("1080p_3g", 16'h89CA, 1'b1, 2);
    run_frames("720p_1g5", 16'h844B, 1'b1, 2);
    run_frames("720p_3g", 16'h884B, 1'b1, 2);
    run_frames("1080i_3g_disabled", 16'h8906, 1'b0, 1);

    @(posedge vid_clk);
    vid_en <= 1'b0;
    repeat (4) @(posedge vid_clk);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected output samples never came out", exp_q.size());
    end
    $display("Errors: sample %0d, line %0d, enable %0d, other %0d",
             sample_errors, line_errors, en_errors, other_errors);
    if (sample_errors + line_errors + en_errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* rtl/smpte352_insert.sv */
// SMPTE 352 payload ID inserter, top level
// TRS detection, line counting, packet sequencing and merge into
// a 20-bit HD-SDI stream with one enabled sample of latency

`timescale 1ns/1ps

module smpte352_insert #(
  parameter smpte352_pkg::line_num_t ANC_LINE_F1 = 11'd10,
  parameter smpte352_pkg::line_num_t ANC_LINE_F2 = 11'd572
) (
  input  logic                      vid_clk,
  input  logic                      vid_reset,
  input  logic                      vid_en,
  input  logic                      enable_anc,
  input  smpte352_pkg::vid_std_t    vid_std,
  input  smpte352_pkg::vid_sample_t vid_data,
  output logic                      vid_out_en,
  output smpte352_pkg::vid_sample_t vid_out_data,
  output smpte352_pkg::line_num_t   line
);

  logic                     eav;
  logic [2:0]               fvh;
  smpte352_pkg::anc_state_t state;

  trs_detect u_trs_detect (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .vid_en    (vid_en),
    .vid_data  (vid_data),
    .eav       (eav),
    .fvh       (fvh)
  );

  line_counter u_line_counter (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .vid_en    (vid_en),
    .eav       (eav),
    .fvh       (fvh),
    .vid_std   (vid_std),
    .line      (line)
  );

  anc_sequencer #(
    .ANC_LINE_F1 (ANC_LINE_F1),
    .ANC_LINE_F2 (ANC_LINE_F2)
  ) u_anc_sequencer (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .vid_en    (vid_en),
    .eav       (eav),
    .line      (line),
    .vid_std   (vid_std),
    .state     (state)
  );

  payload_merge u_payload_merge (
    .vid_clk      (vid_clk),
    .vid_reset    (vid_reset),
    .vid_en       (vid_en),
    .enable_anc   (enable_anc),
    .state        (state),
    .vid_std      (vid_std),
    .vid_data     (vid_data),
    .vid_out_en   (vid_out_en),
    .vid_out_data (vid_out_data)
  );

endmodule

/* rtl/payload_merge.sv */
// Payload merge and output register
// Builds the ADF, header, UDW and checksum words for the current
// sequencer state and overwrites Y, plus C on 3G level A

`timescale 1ns/1ps

module payload_merge (
  input  logic                     vid_clk,
  input  logic                     vid_reset,
  input  logic                     vid_en,
  input  logic                     enable_anc,
  input  smpte352_pkg::anc_state_t state,
  input  smpte352_pkg::vid_std_t   vid_std,
  input  smpte352_pkg::vid_sample_t vid_data,
  output logic                     vid_out_en,
  output smpte352_pkg::vid_sample_t vid_out_data
);

  smpte352_pkg::iface_t    iface;
  logic                    is_3g;
  logic                    pkt_active;
  smpte352_pkg::vid_word_t udw0;
  smpte352_pkg::vid_word_t udw1;
  smpte352_pkg::vid_word_t udw2;
  smpte352_pkg::vid_word_t udw3;
  logic [8:0]              cs_sum;
  smpte352_pkg::vid_word_t pkt_word;

  // Byte with even parity in bit 8 and its inverse in bit 9
  function automatic smpte352_pkg::vid_word_t udw_word(input logic [7:0] data);
    logic par;
    par = ^data;
    return {~par, par, data};
  endfunction

  assign iface = vid_std[27:24];
  assign is_3g = (iface == smpte352_pkg::IFACE_720_3G) ||
                 (iface == smpte352_pkg::IFACE_1080_3G);

  assign udw0 = udw_word(vid_std[31:24]);
  assign udw1 = udw_word(vid_std[23:16]);
  assign udw2 = udw_word(vid_std[15:8]);
  assign udw3 = udw_word(vid_std[7:0]);

  // ------------------------------------------------
  // Checksum, 9-bit sum of DID through UDW3
  // ------------------------------------------------
  // vid_std is quasi-static, so the sum is formed directly
  assign cs_sum = smpte352_pkg::ANC_DID[8:0] + smpte352_pkg::ANC_SDID[8:0] +
                  smpte352_pkg::ANC_DC[8:0] + udw0[8:0] + udw1[8:0] +
                  udw2[8:0] + udw3[8:0];

  assign pkt_active = (state != smpte352_pkg::ST_IDLE) && (state != smpte352_pkg::ST_SKIP);

  always_comb begin
    case (state)
      smpte352_pkg::ST_ADF0: pkt_word = 10'h000;
      smpte352_pkg::ST_ADF1: pkt_word = 10'h3FF;
      smpte352_pkg::ST_ADF2: pkt_word = 10'h3FF;
      smpte352_pkg::ST_DID:  pkt_word = smpte352_pkg::ANC_DID;
      smpte352_pkg::ST_SDID: pkt_word = smpte352_pkg::ANC_SDID;
      smpte352_pkg::ST_DC:   pkt_word = smpte352_pkg::ANC_DC;
      smpte352_pkg::ST_UDW0: pkt_word = udw0;
      smpte352_pkg::ST_UDW1: pkt_word = udw1;
      smpte352_pkg::ST_UDW2: pkt_word = udw2;
      smpte352_pkg::ST_UDW3: pkt_word = udw3;
      smpte352_pkg::ST_CS:   pkt_word = {~cs_sum[8], cs_sum};
      default:               pkt_word = 10'h000;
    endcase
  end

  // ------------------------------------------------
  // Output register
  // ------------------------------------------------
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      vid_out_en <= 1'b0;
    end else begin
      vid_out_en <= vid_en;
    end
  end

  always_ff @(posedge vid_clk) begin
    if (vid_en) begin
      if (enable_anc && pkt_active) begin
        vid_out_data[19:10] <= pkt_word;
        // Level A repeats the packet on C
        vid_out_data[9:0]   <= is_3g ? pkt_word : vid_data[9:0];
      end else begin
        vid_out_data <= vid_data;
      end
    end
  end

  a_out_en_delay : assert property (
    @(posedge vid_clk) disable iff (vid_reset)
    $rose(vid_out_en) |-> $past(vid_en)
  );

endmodule

/* rtl/anc_sequencer.sv */
// ANC packet sequencer
// Starts at each EAV, waits out the LN and CRC words, then steps
// through the eleven packet words on lines that carry the packet

`timescale 1ns/1ps

module anc_sequencer #(
  parameter smpte352_pkg::line_num_t ANC_LINE_F1 = 11'd10,
  parameter smpte352_pkg::line_num_t ANC_LINE_F2 = 11'd572
) (
  input  logic                     vid_clk,
  input  logic                     vid_reset,
  input  logic                     vid_en,
  input  logic                     eav,
  input  smpte352_pkg::line_num_t  line,
  input  smpte352_pkg::vid_std_t   vid_std,
  output smpte352_pkg::anc_state_t state
);

  smpte352_pkg::iface_t iface;
  logic                 is_1080;
  logic                 iface_ok;
  logic                 progressive;
  logic                 anc_line;
  logic [1:0]           skip_cnt;

  assign iface    = vid_std[27:24];
  assign is_1080  = (iface == smpte352_pkg::IFACE_1080_1G5) ||
                    (iface == smpte352_pkg::IFACE_1080_3G);
  assign iface_ok = is_1080 || (iface == smpte352_pkg::IFACE_720_1G5) ||
                    (iface == smpte352_pkg::IFACE_720_3G);

  // 720 carries its own progressive flag
  assign progressive = is_1080 ? vid_std[23] : vid_std[22];

  // Field 2 line only when interlaced
  assign anc_line = iface_ok &&
                    ((line == ANC_LINE_F1) || (!progressive && line == ANC_LINE_F2));

  // ------------------------------------------------
  // State register
  // ------------------------------------------------
  // The line count of the new EAV lands one sample after the pulse,
  // so the line is judged on the first skip sample
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      state    <= smpte352_pkg::ST_IDLE;
      skip_cnt <= 2'd0;
    end else if (vid_en) begin
      case (state)
        smpte352_pkg::ST_IDLE: begin
          if (eav) begin
            state    <= smpte352_pkg::ST_SKIP;
            skip_cnt <= 2'd0;
          end
        end
        smpte352_pkg::ST_SKIP: begin
          skip_cnt <= skip_cnt + 2'd1;
          if (skip_cnt == 2'd0 && !anc_line) begin
            state <= smpte352_pkg::ST_IDLE;
          end else if (skip_cnt == 2'd2) begin
            state <= smpte352_pkg::ST_ADF0;
          end
        end
        smpte352_pkg::ST_CS: begin
          state <= smpte352_pkg::ST_IDLE;
        end
        default: begin
          // Packet words follow each other in enum order
          state <= smpte352_pkg::anc_state_t'(state + 4'd1);
        end
      endcase
    end
  end

  a_start_on_eav : assert property (
    @(posedge vid_clk) disable iff (vid_reset)
    (vid_en && state == smpte352_pkg::ST_IDLE && !eav) |=> state == smpte352_pkg::ST_IDLE
  );

endmodule

/* rtl/line_counter.sv */
// Line counter
// Follows the F and V flags of each EAV: loads the sync line at
// the start of field 1, wraps at the frame total, else increments

`timescale 1ns/1ps

module line_counter (
  input  logic                    vid_clk,
  input  logic                    vid_reset,
  input  logic                    vid_en,
  input  logic                    eav,
  input  logic [2:0]              fvh,
  input  smpte352_pkg::vid_std_t  vid_std,
  output smpte352_pkg::line_num_t line
);

  smpte352_pkg::iface_t    iface;
  smpte352_pkg::line_num_t frame_total;
  smpte352_pkg::line_num_t sync_line;
  logic                    v_prev;
  logic                    field1_start;

  assign iface = vid_std[27:24];

  // ------------------------------------------------
  // Standard decode
  // ------------------------------------------------
  always_comb begin
    if (iface == smpte352_pkg::IFACE_720_1G5 || iface == smpte352_pkg::IFACE_720_3G) begin
      frame_total = smpte352_pkg::LINES_720;
      sync_line   = smpte352_pkg::SYNC_LINE_720P;
    end else begin
      frame_total = smpte352_pkg::LINES_1080;
      // Bit 23 set for progressive transport
      sync_line   = vid_std[23] ? smpte352_pkg::SYNC_LINE_1080P :
                                  smpte352_pkg::SYNC_LINE_1080I;
    end
  end

  // V falling in field 1
  assign field1_start = !fvh[1] && v_prev && !fvh[2];

  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      line   <= '0;
      v_prev <= 1'b0;
    end else if (vid_en && eav) begin
      v_prev <= fvh[1];
      if (field1_start) begin
        line <= sync_line;
      end else if (line >= frame_total) begin
        line <= 11'd1;
      end else begin
        line <= line + 11'd1;
      end
    end
  end

  // Holds across standard changes too
  a_line_range : assert property (
    @(posedge vid_clk) disable iff (vid_reset)
    line <= smpte352_pkg::LINES_1080
  );

endmodule

/* rtl/trs_detect.sv */
// TRS detector
// Watches the Y channel for 3FF 000 000 XYZ and flags every EAV,
// capturing the F, V and H bits of its XYZ word

`timescale 1ns/1ps

module trs_detect (
  input  logic                      vid_clk,
  input  logic                      vid_reset,
  input  logic                      vid_en,
  input  smpte352_pkg::vid_sample_t vid_data,
  output logic                      eav,
  output logic [2:0]                fvh
);

  smpte352_pkg::vid_word_t y_word;
  // 0 idle, 1 after 3FF, 2 after 3FF 000, 3 after 3FF 000 000
  logic [1:0] run_cnt;
  logic       xyz_eav;

  assign y_word = vid_data[19:10];

  // XYZ word of an EAV has H set
  assign xyz_eav = (run_cnt == 2'd3) && y_word[6];

  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      run_cnt <= 2'd0;
    end else if (vid_en) begin
      if (y_word == 10'h3FF) begin
        run_cnt <= 2'd1;
      end else if (y_word == 10'h000 && (run_cnt == 2'd1 || run_cnt == 2'd2)) begin
        run_cnt <= run_cnt + 2'd1;
      end else begin
        run_cnt <= 2'd0;
      end
    end
  end

  // ------------------------------------------------
  // EAV strobe and flags
  // ------------------------------------------------
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      eav <= 1'b0;
      fvh <= 3'b000;
    end else if (vid_en) begin
      eav <= xyz_eav;
      if (xyz_eav) begin
        // F, V, H
        fvh <= y_word[8:6];
      end
    end
  end

  // A TRS takes four samples, so two EAVs can never be back to back
  a_eav_single : assert property (
    @(posedge vid_clk) disable iff (vid_reset)
    (vid_en && eav) |=> !eav
  );

endmodule

/* rtl/smpte352_pkg.sv */
// SMPTE 352 payload ID inserter shared definitions
// Video word types, interface codes, line constants and the
// ANC sequencer state encoding

package smpte352_pkg;

  // ------------------------------------------------
  // Video word types
  // ------------------------------------------------
  // One 10-bit channel sample
  typedef logic [9:0]  vid_word_t;
  // Y in 19:10, C in 9:0
  typedef logic [19:0] vid_sample_t;
  typedef logic [10:0] line_num_t;
  // Payload identifier, byte 1 in 31:24
  typedef logic [31:0] vid_std_t;
  typedef logic [3:0]  iface_t;

  // ------------------------------------------------
  // Interface codes, low nibble of byte 1
  // ------------------------------------------------
  localparam iface_t IFACE_720_1G5  = 4'h4;
  localparam iface_t IFACE_1080_1G5 = 4'h5;
  localparam iface_t IFACE_720_3G   = 4'h8;
  localparam iface_t IFACE_1080_3G  = 4'h9;

  // ANC header words, parity already included
  localparam vid_word_t ANC_DID  = 10'h241;
  localparam vid_word_t ANC_SDID = 10'h101;
  localparam vid_word_t ANC_DC   = 10'h104;

  // Total lines per frame
  localparam line_num_t LINES_1080 = 11'd1125;
  localparam line_num_t LINES_720  = 11'd750;

  // Line loaded when V falls in field 1
  localparam line_num_t SYNC_LINE_1080I = 11'd21;
  localparam line_num_t SYNC_LINE_1080P = 11'd42;
  localparam line_num_t SYNC_LINE_720P  = 11'd26;

  // ------------------------------------------------
  // ANC sequencer states, packet words in order
  // ------------------------------------------------
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_SKIP,
    ST_ADF0,
    ST_ADF1,
    ST_ADF2,
    ST_DID,
    ST_SDID,
    ST_DC,
    ST_UDW0,
    ST_UDW1,
    ST_UDW2,
    ST_UDW3,
    ST_CS
  } anc_state_t;

endpackage
